// File: src/aer_macros.svh
`ifndef AER_MACROS_SVH
`define AER_MACROS_SVH

// Pixel array geometry
`define AER_ROWS    8    // Pixel rows
`define AER_COLS    8    // Pixel columns

// Two-level arbitration grid
`define AER_GRP     2    // Pixels per group edge
`define AER_GROUPS  4    // Groups per array edge

// Address and timestamp widths
`define AER_ADDR_W  3    // Row or column address bits
`define AER_TS_W    16   // Wall-clock bits

// Row, column, polarity and timestamp packed together
`define AER_EVENT_W 23   // 3 + 3 + 1 + 16

`endif

// File: src/aer_pkg.sv
`include "aer_macros.svh"

package aer_pkg;

    // Set code from one pixel, both bits low means idle
    typedef logic [1:0] pol_req_t;

    localparam int POL_ON_BIT  = 0;               // Brightness went up
    localparam int POL_OFF_BIT = 1;               // Brightness went down

    // One row or column index
    typedef logic [`AER_ADDR_W-1:0] addr_t;

    // Free-running wall clock value
    typedef logic [`AER_TS_W-1:0] timestamp_t;

    // Outgoing address-event word, row sits in the top bits
    typedef struct packed {
        addr_t      row;                          // Pixel row
        addr_t      col;                          // Pixel column
        logic       pol;                          // 1 = ON, 0 = OFF
        timestamp_t ts;                           // Wall clock at grant
    } event_t;

endpackage

// File: src/pixel_request_latch.sv
`timescale 1ns/1ps
`include "aer_macros.svh"

module pixel_request_latch (
    input  logic                                             clk_i,
    input  logic                                             reset_i,
    input  aer_pkg::pol_req_t [`AER_ROWS-1:0][`AER_COLS-1:0] set_i,     // Set strobes
    input  logic [`AER_ROWS-1:0][`AER_COLS-1:0]              gnt_i,     // One-hot grant
    output logic [`AER_ROWS-1:0][`AER_COLS-1:0]              pending_o, // Waiting pixels
    output logic [`AER_ROWS-1:0][`AER_COLS-1:0]              pol_o      // Stored polarity
);

    logic [`AER_ROWS-1:0][`AER_COLS-1:0] pend_q;    // Pending flags
    logic [`AER_ROWS-1:0][`AER_COLS-1:0] pol_q;     // Captured polarity
    logic [`AER_ROWS-1:0][`AER_COLS-1:0] new_req;   // Accepted set this cycle

    // A set only counts on an idle pixel that is not being granted right now
    always_comb
    begin
        for (int r = 0; r < `AER_ROWS; r++)
        begin
            for (int c = 0; c < `AER_COLS; c++)
            begin
                new_req[r][c] = (set_i[r][c][aer_pkg::POL_ON_BIT] ||
                                 set_i[r][c][aer_pkg::POL_OFF_BIT]) &&
                                !pend_q[r][c] && !gnt_i[r][c];
            end
        end
    end

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            pend_q <= '0;                         // Nothing waiting
        end
        else
        begin
            for (int r = 0; r < `AER_ROWS; r++)
            begin
                for (int c = 0; c < `AER_COLS; c++)
                begin
                    if (gnt_i[r][c])
                        pend_q[r][c] <= 1'b0;     // Served, drop request
                    else if (new_req[r][c])
                        pend_q[r][c] <= 1'b1;     // Fresh request
                end
            end
        end
    end

    // ON wins when both bits are raised, so the ON bit is the polarity
    always_ff @(posedge clk_i)
    begin
        for (int r = 0; r < `AER_ROWS; r++)
        begin
            for (int c = 0; c < `AER_COLS; c++)
            begin
                if (new_req[r][c])
                    pol_q[r][c] <= set_i[r][c][aer_pkg::POL_ON_BIT];
            end
        end
    end

    assign pending_o = pend_q;
    assign pol_o     = pol_q;                     // Valid while pending

endmodule

// File: src/rr_group_arbiter.sv
`timescale 1ns/1ps

module rr_group_arbiter #(
    parameter int N = 4                                  // Requesters, power of two
) (
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  logic [N-1:0]         req_i,                  // Request vector
    input  logic                 advance_i,              // Choice is taken this cycle
    input  logic                 hold_i,                 // Stay on current choice
    output logic [$clog2(N)-1:0] gnt_idx_o,              // Chosen requester
    output logic                 gnt_any_o               // Some requester chosen
);

    localparam int IDX_W = $clog2(N);

    logic [IDX_W-1:0] ptr_q;                             // Highest-priority slot
    logic [IDX_W-1:0] pick;                              // First request at or after ptr
    logic             found;                             // Any request seen

    // Scan from the pointer upward, wrapping through the index width
    always_comb
    begin
        logic [IDX_W-1:0] cand;
        pick  = ptr_q;
        found = 1'b0;
        for (int i = 0; i < N; i++)
        begin
            cand = ptr_q + IDX_W'(i);                    // Wraps modulo N
            if (!found && req_i[cand])
            begin
                pick  = cand;
                found = 1'b1;
            end
        end
    end

    // Pointer update only when the choice was actually used
    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            ptr_q <= '0;                                 // Start at requester 0
        end
        else if (advance_i && found)
        begin
            if (hold_i)
                ptr_q <= pick;                           // Keep the same winner on top
            else
                ptr_q <= pick + IDX_W'(1);               // Rotate past the winner
        end
    end

    assign gnt_idx_o = pick;
    assign gnt_any_o = found;

endmodule

// File: src/hier_pixel_arbiter.sv
`timescale 1ns/1ps
`include "aer_macros.svh"

module hier_pixel_arbiter (
    input  logic                                clk_i,
    input  logic                                reset_i,
    input  logic [`AER_ROWS-1:0][`AER_COLS-1:0] pending_i,   // From the request latch
    output logic [`AER_ROWS-1:0][`AER_COLS-1:0] gnt_o,       // One-hot grant pulse
    output logic                                gnt_valid_o, // Grant this cycle
    output aer_pkg::addr_t                      gnt_row_o,   // Granted row
    output aer_pkg::addr_t                      gnt_col_o,   // Granted column
    output logic                                release_o    // Array emptied by this grant
);

    localparam int GRP_N  = `AER_GRP * `AER_GRP;         // Pixels per group
    localparam int TOP_N  = `AER_GROUPS * `AER_GROUPS;   // Groups in the array
    localparam int GRP_IW = $clog2(GRP_N);               // In-group index bits
    localparam int TOP_IW = $clog2(TOP_N);               // Group index bits
    localparam int GW     = $clog2(`AER_GROUPS);         // Group coordinate bits
    localparam int PW     = $clog2(`AER_GRP);            // In-group coordinate bits

    logic [`AER_ROWS-1:0][`AER_COLS-1:0] eff_pend;       // Pending minus the live grant
    logic [`AER_ROWS-1:0][`AER_COLS-1:0] gnt_d;
    logic [`AER_ROWS-1:0][`AER_COLS-1:0] gnt_q;
    logic [TOP_N-1:0]                    grp_req;        // Group has work
    logic [TOP_N-1:0]                    grp_multi;      // Group has two or more
    logic [TOP_N-1:0]                    lo_adv;         // Group winner used
    logic [GRP_IW-1:0]                   lo_idx [TOP_N];
    logic [TOP_IW-1:0]                   up_idx;         // Selected group
    logic                                up_any;
    logic [GRP_IW-1:0]                   sel_pix;        // Pixel inside selected group
    logic                                fire;           // Grant issued next edge
    logic                                release_d;
    aer_pkg::addr_t                      row_d;
    aer_pkg::addr_t                      col_d;
    logic                                valid_q;
    logic                                release_q;
    aer_pkg::addr_t                      row_q;
    aer_pkg::addr_t                      col_q;

    // Latch clears at the end of the grant cycle, so hide that pixel now
    assign eff_pend = pending_i & ~gnt_q;

    // Lower level, one arbiter per 2x2 group
    for (genvar g = 0; g < TOP_N; g++)
    begin : g_grp
        localparam int GR = g / `AER_GROUPS;             // Group row
        localparam int GC = g % `AER_GROUPS;             // Group column

        logic [GRP_N-1:0] grp_bits;

        for (genvar k = 0; k < GRP_N; k++)
        begin : g_pix
            assign grp_bits[k] = eff_pend[GR*`AER_GRP + k/`AER_GRP][GC*`AER_GRP + k%`AER_GRP];
        end

        assign grp_req[g]   = |grp_bits;
        assign grp_multi[g] = ($countones(grp_bits) > 1);
        assign lo_adv[g]    = up_any && (up_idx == TOP_IW'(g));   // Only the served group moves

        rr_group_arbiter #(.N(GRP_N)) u_grp_arb (
            .clk_i     (clk_i),
            .reset_i   (reset_i),
            .req_i     (grp_bits),
            .advance_i (lo_adv[g]),
            .hold_i    (1'b0),                           // Always rotate inside a group
            .gnt_idx_o (lo_idx[g]),
            .gnt_any_o ()
        );
    end

    // Upper level stays on a group until its last pixel goes
    rr_group_arbiter #(.N(TOP_N)) u_top_arb (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .req_i     (grp_req),
        .advance_i (up_any),
        .hold_i    (grp_multi[up_idx]),                  // Last pixel acts as release
        .gnt_idx_o (up_idx),
        .gnt_any_o (up_any)
    );

    assign sel_pix = lo_idx[up_idx];
    assign fire    = up_any;                             // Chosen group always has a pixel

    // Group coordinate above in-group coordinate
    assign row_d = {up_idx[TOP_IW-1 -: GW], sel_pix[GRP_IW-1 -: PW]};
    assign col_d = {up_idx[GW-1:0], sel_pix[PW-1:0]};

    // Last pending pixel of the only busy group
    assign release_d = fire && $onehot(grp_req) && !grp_multi[up_idx];

    always_comb
    begin
        gnt_d = '0;
        if (fire)
            gnt_d[row_d][col_d] = 1'b1;
    end

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            gnt_q     <= '0;
            valid_q   <= 1'b0;
            release_q <= 1'b0;
        end
        else
        begin
            gnt_q     <= gnt_d;
            valid_q   <= fire;
            release_q <= release_d;
        end
    end

    always_ff @(posedge clk_i)
    begin
        row_q <= row_d;                                  // Qualified by valid_q
        col_q <= col_d;
    end

    assign gnt_o       = gnt_q;
    assign gnt_valid_o = valid_q;
    assign gnt_row_o   = row_q;
    assign gnt_col_o   = col_q;
    assign release_o   = release_q;

endmodule

// File: src/address_event_encoder.sv
`timescale 1ns/1ps
`include "aer_macros.svh"

module address_event_encoder (
    input  logic                                clk_i,
    input  logic                                reset_i,
    input  logic                                gnt_valid_i,   // Grant cycle
    input  aer_pkg::addr_t                      gnt_row_i,     // Granted row
    input  aer_pkg::addr_t                      gnt_col_i,     // Granted column
    input  logic [`AER_ROWS-1:0][`AER_COLS-1:0] pol_i,         // Pending polarity
    output logic                                event_valid_o, // Event strobe
    output aer_pkg::event_t                     event_o        // Packed event word
);

    aer_pkg::timestamp_t     ts_q;                // Wall clock
    logic                    pol_sel;             // Polarity of granted pixel
    logic [`AER_EVENT_W-1:0] word_d;              // Word to capture
    aer_pkg::event_t         event_q;
    logic                    valid_q;

    // Latch still holds the polarity during the grant cycle
    assign pol_sel = pol_i[gnt_row_i][gnt_col_i];

    // Row, column, polarity, timestamp from MSB down
    assign word_d = {gnt_row_i, gnt_col_i, pol_sel, ts_q};

    // Reads 0 in the first cycle out of reset and wraps freely
    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
            ts_q <= '0;
        else
            ts_q <= ts_q + 1'b1;
    end

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
            valid_q <= 1'b0;                      // No event out of reset
        else
            valid_q <= gnt_valid_i;               // One cycle behind the grant
    end

    always_ff @(posedge clk_i)
    begin
        if (gnt_valid_i)
            event_q <= word_d;                    // Held until the next grant
    end

    assign event_valid_o = valid_q;
    assign event_o       = event_q;

endmodule

// File: src/aer_pixel_array.sv
`timescale 1ns/1ps
`include "aer_macros.svh"

module aer_pixel_array (
    input  logic                                             clk_i,
    input  logic                                             reset_i,
    input  aer_pkg::pol_req_t [`AER_ROWS-1:0][`AER_COLS-1:0] set_i,         // Pixel sets
    output logic [`AER_ROWS-1:0][`AER_COLS-1:0]              gnt_o,         // Grant pulse
    output logic                                             event_valid_o, // Event strobe
    output aer_pkg::event_t                                  event_o,       // Event word
    output logic                                             array_release_o // Array drained
);

    logic [`AER_ROWS-1:0][`AER_COLS-1:0] pending;  // Latch to arbiter
    logic [`AER_ROWS-1:0][`AER_COLS-1:0] pol;      // Latch to encoder
    logic [`AER_ROWS-1:0][`AER_COLS-1:0] gnt;      // Arbiter back to latch
    logic                                gnt_valid;
    aer_pkg::addr_t                      gnt_row;
    aer_pkg::addr_t                      gnt_col;

    pixel_request_latch u_latch (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .set_i     (set_i),
        .gnt_i     (gnt),
        .pending_o (pending),
        .pol_o     (pol)
    );

    hier_pixel_arbiter u_arbiter (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .pending_i   (pending),
        .gnt_o       (gnt),
        .gnt_valid_o (gnt_valid),
        .gnt_row_o   (gnt_row),
        .gnt_col_o   (gnt_col),
        .release_o   (array_release_o)
    );

    address_event_encoder u_encoder (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .gnt_valid_i   (gnt_valid),
        .gnt_row_i     (gnt_row),
        .gnt_col_i     (gnt_col),
        .pol_i         (pol),
        .event_valid_o (event_valid_o),
        .event_o       (event_o)
    );

    assign gnt_o = gnt;                           // Grant is also visible outside

endmodule

// File: testbench/aer_pixel_array_tb.sv
`timescale 1ns/1ps
`include "aer_macros.svh"

module aer_pixel_array_tb;

    localparam int CLK_PERIOD   = 8;                     // ns
    localparam int RESET_CYCLES = 8;
    localparam int QUIET_CYCLES = 4;                     // Idle stretch before any set
    localparam int RAND_CYCLES  = 2000;
    localparam int DRAIN_CYCLES = 200;
    localparam int MARGIN       = 100;
    localparam int SEED         = 91163;
    localparam int WATCHDOG_NS  = (RESET_CYCLES + QUIET_CYCLES + RAND_CYCLES +
                                   DRAIN_CYCLES + MARGIN) * CLK_PERIOD;

    logic                                             clk_i;
    logic                                             reset_i;
    aer_pkg::pol_req_t [`AER_ROWS-1:0][`AER_COLS-1:0] set_i;
    logic [`AER_ROWS-1:0][`AER_COLS-1:0]              gnt_o;
    logic                                             event_valid_o;
    aer_pkg::event_t                                  event_o;
    logic                                             array_release_o;

    logic [`AER_ROWS-1:0][`AER_COLS-1:0] m_pend;         // Model pending flags
    logic [`AER_ROWS-1:0][`AER_COLS-1:0] m_pol;          // Model polarity, 1 = ON
    logic [`AER_ROWS-1:0][`AER_COLS-1:0] m_new;          // Became pending at the last edge
    logic [`AER_ROWS-1:0][`AER_COLS-1:0] vis_prev;       // What the arbiter saw last cycle
    logic [`AER_EVENT_W-1:0]             exp_events[$];  // Events owed by the DUT
    int unsigned                         cycle_cnt;      // 0 in first cycle out of reset
    int                                  stay_grp;       // Group the next grant must use
    bit                                  running;
    int                                  accepted;
    int                                  repeat_sets;
    int                                  grants_seen;
    int                                  events_seen;
    int                                  releases_seen;

    aer_pixel_array u_aer_pixel_array (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .set_i           (set_i),
        .gnt_o           (gnt_o),
        .event_valid_o   (event_valid_o),
        .event_o         (event_o),
        .array_release_o (array_release_o)
    );

    initial clk_i = 1'b0;
    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    task automatic report_error(input string msg);
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    function automatic int group_of(input int row, input int col);
        return (row / `AER_GRP) * `AER_GROUPS + (col / `AER_GRP);
    endfunction

    // Quiet stretches let the array drain, busy ones pile up repeat sets
    task automatic drive_random_sets(input int n);
        int unsigned odds;
        odds = ((n / 250) % 2 == 0) ? 160 : 40;
        for (int r = 0; r < `AER_ROWS; r++)
        begin
            for (int c = 0; c < `AER_COLS; c++)
            begin
                if ($urandom % odds == 0)
                    set_i[r][c] = aer_pkg::pol_req_t'($urandom % 3 + 1);   // ON, OFF or both
                else
                    set_i[r][c] = 2'b00;
            end
        end
    endtask

    // Runs mid-cycle, where DUT outputs and driven sets are both settled
    task automatic check_cycle();
        int                                  hits;
        int                                  g_row;
        int                                  g_col;
        bit                                  exp_release;
        logic [`AER_EVENT_W-1:0]             exp_word;
        logic [`AER_ROWS-1:0][`AER_COLS-1:0] vis_now;
        logic [`AER_ROWS-1:0][`AER_COLS-1:0] old_vis;
        hits  = 0;
        g_row = -1;
        g_col = -1;
        for (int r = 0; r < `AER_ROWS; r++)
        begin
            for (int c = 0; c < `AER_COLS; c++)
            begin
                if (gnt_o[r][c])
                begin
                    hits++;
                    g_row = r;
                    g_col = c;
                end
            end
        end

        assert (hits <= 1)
        else report_error($sformatf("grant not one-hot, %0d bits set", hits));
        assert ((gnt_o & ~vis_prev) == '0)
        else report_error($sformatf("grant at row %0d col %0d was not pending", g_row, g_col));
        assert ((hits != 0) == (vis_prev != '0))
        else report_error($sformatf("grant count %0d with visible requests %h", hits, vis_prev));
        if (stay_grp >= 0)
        begin
            assert (hits == 1 && group_of(g_row, g_col) == stay_grp)
            else report_error($sformatf("grant left group %0d while it still had work", stay_grp));
        end

        // Release goes with the grant that takes the last request the arbiter saw
        exp_release = (hits == 1) && (vis_prev == gnt_o);
        assert (array_release_o == exp_release)
        else report_error($sformatf("release %0b, expected %0b", array_release_o, exp_release));
        if (array_release_o)
            releases_seen++;

        // Event from the previous grant is due now
        if (exp_events.size() > 0)
        begin
            exp_word = exp_events.pop_front();
            assert (event_valid_o === 1'b1)
            else report_error("event strobe missing one cycle after a grant");
            assert (event_o === exp_word)
            else report_error($sformatf("event word %h, expected %h", event_o, exp_word));
            events_seen++;
        end
        else
        begin
            assert (event_valid_o === 1'b0)
            else report_error("event strobe without a grant in the cycle before");
        end

        if (hits == 1)
        begin
            exp_word = {aer_pkg::addr_t'(g_row), aer_pkg::addr_t'(g_col),
                        m_pol[g_row][g_col], aer_pkg::timestamp_t'(cycle_cnt)};
            exp_events.push_back(exp_word);
            grants_seen++;
        end

        // Older work left in the granted group keeps the upper level there
        vis_now  = m_pend & ~gnt_o;
        old_vis  = vis_now & ~m_new;
        stay_grp = -1;
        if (hits == 1)
        begin
            for (int r = 0; r < `AER_ROWS; r++)
                for (int c = 0; c < `AER_COLS; c++)
                    if (old_vis[r][c] && group_of(r, c) == group_of(g_row, g_col))
                        stay_grp = group_of(g_row, g_col);
        end
        vis_prev = vis_now;

        // Latch rule for the coming edge
        m_new = '0;
        for (int r = 0; r < `AER_ROWS; r++)
        begin
            for (int c = 0; c < `AER_COLS; c++)
            begin
                if (gnt_o[r][c])
                    m_pend[r][c] = 1'b0;                 // A set in the grant cycle is lost
                else if (set_i[r][c] != 2'b00)
                begin
                    if (m_pend[r][c])
                        repeat_sets++;                   // Stored polarity is kept
                    else
                    begin
                        m_pend[r][c] = 1'b1;
                        m_pol[r][c]  = set_i[r][c][0];   // ON wins over OFF
                        m_new[r][c]  = 1'b1;
                        accepted++;
                    end
                end
            end
        end
        cycle_cnt++;
    endtask

    always @(negedge clk_i)
    begin
        if (running)
            check_cycle();
    end

    initial
    begin
        void'($urandom(SEED));
        reset_i       = 1'b1;
        set_i         = '0;
        running       = 1'b0;
        m_pend        = '0;
        m_pol         = '0;
        m_new         = '0;
        vis_prev      = '0;
        cycle_cnt     = 0;
        stay_grp      = -1;
        accepted      = 0;
        repeat_sets   = 0;
        grants_seen   = 0;
        events_seen   = 0;
        releases_seen = 0;

        repeat (RESET_CYCLES) @(posedge clk_i);
        #1;
        reset_i = 1'b0;
        running = 1'b1;                                  // Wall clock reads 0 from here

        repeat (QUIET_CYCLES)
        begin
            @(posedge clk_i);
            #1;
        end

        for (int n = 0; n < RAND_CYCLES; n++)
        begin
            drive_random_sets(n);
            @(posedge clk_i);
            #1;
        end

        set_i = '0;
        repeat (DRAIN_CYCLES)
        begin
            @(posedge clk_i);
            #1;
        end

        assert (m_pend == '0)
        else report_error("pixels still pending after the drain period");
        assert (exp_events.size() == 0 && events_seen == accepted)
        else report_error($sformatf("%0d events for %0d accepted requests",
                                    events_seen, accepted));
        assert (grants_seen == accepted)
        else report_error($sformatf("%0d grants for %0d accepted requests",
                                    grants_seen, accepted));
        assert (releases_seen > 0 && repeat_sets > 0)
        else report_error("stimulus never drained the array or never repeated a set");

        $display("%0d requests, %0d repeat sets, %0d releases",
                 accepted, repeat_sets, releases_seen);
        $display("ALL TESTS PASSED");
        $finish;
    end

    // Hard stop in case the DUT or the stimulus stalls
    initial
    begin
        #(WATCHDOG_NS);
        $display("Watchdog expired at %0t ns before the test finished", $time);
        $display("SOME TESTS FAILED");
        $fatal(1, "watchdog timeout");
    end

endmodule

// File: aer_pixel_array.f
+incdir+src
src/aer_pkg.sv
src/pixel_request_latch.sv
src/rr_group_arbiter.sv
src/hier_pixel_arbiter.sv
src/address_event_encoder.sv
src/aer_pixel_array.sv
testbench/aer_pixel_array_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the AER pixel array testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f aer_pixel_array.f \
    --top-module aer_pixel_array_tb \
    -Mdir obj_dir

# The run itself may stop with a nonzero status; the printed result decides
output=$(./obj_dir/Vaer_pixel_array_tb 2>&1) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "ALL TESTS PASSED"; then
    exit 0
fi
exit 1
